// ==== dual_bank_icache.f ====
dual_bank_icache_pkg.sv
icache_bank.sv
icache_line_merge.sv
dual_bank_icache.sv
dual_bank_icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dual_bank_icache_tb \
	-f dual_bank_icache.f -o sim_dual_bank_icache &&
./obj_dir/sim_dual_bank_icache ||
{ echo "build or simulation did not complete"; exit 1; }

// ==== dual_bank_icache_tb.sv ====
/*
 * Testbench for the two-bank instruction cache
 * Clock, reset, directed and random stimulus, timeout
 * Reference model of tags, valid bits and data per bank, way and set
 */
`timescale 1ns/1ns

module dual_bank_icache_tb;
	import dual_bank_icache_pkg::*;

	localparam int N_RANDOM = 1500;
	// Reset, the directed part and the drain stay well under 110 cycles
	localparam int CYCLE_LIMIT = 2 * (10 + 110 + N_RANDOM);

	logic clk;
	logic rst;
	logic fetch_valid;
	logic [ADDR_W-1:0] fetch_addr;
	logic fetch_ready;
	logic line_valid;
	logic [LINE_W-1:0] line_lo;
	logic [LINE_W-1:0] line_hi;
	logic hit;
	logic [ADDR_W-1:0] miss_addr;
	logic line_ready;
	logic fill_valid;
	logic [ADDR_W-1:0] fill_addr;
	logic [WAY_W-1:0] fill_way;
	logic [LINE_W-1:0] fill_data;
	logic inv_valid;
	logic inv_all;
	logic [ADDR_W-1:0] inv_addr;
	logic snoop_valid;
	logic [ADDR_W-1:0] snoop_addr;
	logic [AGENT_ID_W-1:0] snoop_id;

	integer seed;
	int cycle_cnt = 0;

	// Model state where bank 0 is the even bank and bank 1 the odd bank
	logic [TAG_W-1:0] m_tag [2][WAYS][SETS];
	logic m_vld [2][WAYS][SETS];
	logic [LINE_W-1:0] m_data [2][WAYS][SETS];

	// Expected content of the result slot
	logic exp_valid;
	logic exp_hit;
	logic [LINE_W-1:0] exp_lo;
	logic [LINE_W-1:0] exp_hi;
	logic [ADDR_W-1:0] exp_miss;

	dual_bank_icache dut (
		.clk(clk),
		.rst(rst),
		.fetch_valid_i(fetch_valid),
		.fetch_addr_i(fetch_addr),
		.fetch_ready_o(fetch_ready),
		.line_valid_o(line_valid),
		.line_lo_o(line_lo),
		.line_hi_o(line_hi),
		.hit_o(hit),
		.miss_addr_o(miss_addr),
		.line_ready_i(line_ready),
		.fill_valid_i(fill_valid),
		.fill_addr_i(fill_addr),
		.fill_way_i(fill_way),
		.fill_data_i(fill_data),
		.inv_valid_i(inv_valid),
		.inv_all_i(inv_all),
		.inv_addr_i(inv_addr),
		.snoop_valid_i(snoop_valid),
		.snoop_addr_i(snoop_addr),
		.snoop_id_i(snoop_id)
	);

	always #10 clk = ~clk;

	// Stops a run that never reaches its end
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("test failed");
			$fatal(1, "simulation ran past its cycle limit of %0d cycles", CYCLE_LIMIT);
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: actual %h expected %h", name, actual, expected);
			$display("test failed");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	function automatic logic [31:0] draw();
		draw = $random(seed);
	endfunction

	function automatic logic [LINE_W-1:0] rand_line();
		rand_line = {draw(), draw(), draw(), draw()};
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
			input logic [INDEX_W-1:0] idx, input logic odd, input logic [OFFSET_W-1:0] off);
		make_addr = {tag, idx, odd, off};
	endfunction

	// Small pool of tags and sets so that fills are found again
	// Set 63 in an odd line makes the next line wrap into set 0 of the next tag
	function automatic logic [ADDR_W-1:0] pool_addr();
		logic [31:0] r;
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] idx;
		r = draw();
		case (r[1:0])
			2'd0: tag = 21'h1;
			2'd1: tag = 21'h2;
			2'd2: tag = 21'h3;
			default: tag = 21'h1FFFFF;
		endcase
		case (r[3:2])
			2'd0: idx = 6'd0;
			2'd1: idx = 6'd10;
			2'd2: idx = 6'd11;
			default: idx = 6'd63;
		endcase
		pool_addr = make_addr(tag, idx, r[4], r[8:5]);
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================

	task automatic lookup_bank(input int bank, input logic [ADDR_W-1:0] addr,
			output logic found, output logic [LINE_W-1:0] data);
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] idx;
		tag = addr[ADDR_W-1 -: TAG_W];
		idx = addr[OFFSET_W+1 +: INDEX_W];
		found = 1'b0;
		data = '0;
		// Walking down leaves the lowest matching way
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (m_vld[bank][w][idx] && m_tag[bank][w][idx] == tag) begin
				found = 1'b1;
				data = m_data[bank][w][idx];
			end
		end
	endtask

	// Applies invalidate, fill and snoop clear in rising order of priority
	task automatic apply_updates();
		logic [WAYS-1:0] clr;
		logic sb;
		logic fb;
		logic [INDEX_W-1:0] si;
		logic [INDEX_W-1:0] fi;
		logic [TAG_W-1:0] st;
		logic [TAG_W-1:0] ft;
		sb = snoop_addr[OFFSET_W];
		si = snoop_addr[OFFSET_W+1 +: INDEX_W];
		st = snoop_addr[ADDR_W-1 -: TAG_W];
		fb = fill_addr[OFFSET_W];
		fi = fill_addr[OFFSET_W+1 +: INDEX_W];
		ft = fill_addr[ADDR_W-1 -: TAG_W];
		clr = '0;
		// Snoop compares the tags held before this edge and also a fill of the snooped line
		if (snoop_valid && snoop_id != CACHE_ID) begin
			for (int w = 0; w < WAYS; w++) begin
				if (m_tag[sb][w][si] == st)
					clr[w] = 1'b1;
				if (fill_valid && fb == sb && fi == si && fill_way == WAY_W'(w) && ft == st)
					clr[w] = 1'b1;
			end
		end
		if (inv_valid) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					if (inv_all)
						m_vld[0][w][s] = 1'b0;
					if (inv_all)
						m_vld[1][w][s] = 1'b0;
				end
				if (!inv_all)
					m_vld[inv_addr[OFFSET_W]][w][inv_addr[OFFSET_W+1 +: INDEX_W]] = 1'b0;
			end
		end
		if (fill_valid) begin
			m_tag[fb][fill_way][fi] = ft;
			m_vld[fb][fill_way][fi] = 1'b1;
			m_data[fb][fill_way][fi] = fill_data;
		end
		for (int w = 0; w < WAYS; w++) begin
			if (clr[w])
				m_vld[sb][w][si] = 1'b0;
		end
	endtask

	// Works out what the coming clock edge does to the result slot and the arrays
	task automatic model_edge();
		logic ready;
		logic eh;
		logic oh;
		logic [LINE_W-1:0] ed;
		logic [LINE_W-1:0] od;
		logic [ADDR_W-1:0] line_no;
		logic [ADDR_W-1:0] el;
		logic [ADDR_W-1:0] ol;
		ready = !exp_valid || line_ready;
		if (ready && fetch_valid) begin
			line_no = fetch_addr >> OFFSET_W;
			// The even line of the pair is the next even line number at or above
			el = (line_no + 32'(line_no[0])) << OFFSET_W;
			ol = (line_no | 32'd1) << OFFSET_W;
			lookup_bank(0, el, eh, ed);
			lookup_bank(1, ol, oh, od);
			exp_hit = eh && oh;
			exp_lo = line_no[0] ? od : ed;
			exp_hi = line_no[0] ? ed : od;
			exp_miss = !eh ? el : (!oh ? ol : 32'd0);
		end
		if (ready)
			exp_valid = fetch_valid;
		apply_updates();
	endtask

	// ========================================================================
	// Cycle stepping
	// ========================================================================

	task automatic check_outputs();
		check_value("line_valid_o", 128'(line_valid), 128'(exp_valid));
		check_value("fetch_ready_o", 128'(fetch_ready), 128'(!exp_valid || line_ready));
		if (exp_valid) begin
			check_value("hit_o", 128'(hit), 128'(exp_hit));
			check_value("miss_addr_o", 128'(miss_addr), 128'(exp_miss));
			// Line data is only defined when both lines are present
			if (exp_hit) begin
				check_value("line_lo_o", line_lo, exp_lo);
				check_value("line_hi_o", line_hi, exp_hi);
			end
		end
	endtask

	// Outputs are sampled 1 ns after the inputs, which were driven 2 ns past the edge
	task automatic step();
		#1;
		check_outputs();
		model_edge();
		@(posedge clk);
		#2;
	endtask

	task automatic idle_inputs();
		fetch_valid = 1'b0;
		fetch_addr = '0;
		line_ready = 1'b1;
		fill_valid = 1'b0;
		fill_addr = '0;
		fill_way = '0;
		fill_data = '0;
		inv_valid = 1'b0;
		inv_all = 1'b0;
		inv_addr = '0;
		snoop_valid = 1'b0;
		snoop_addr = '0;
		snoop_id = '0;
	endtask

	task automatic do_fetch(input logic [ADDR_W-1:0] addr);
		fetch_valid = 1'b1;
		fetch_addr = addr;
		step();
		fetch_valid = 1'b0;
	endtask

	task automatic do_fill(input logic [ADDR_W-1:0] addr, input logic [WAY_W-1:0] way);
		fill_valid = 1'b1;
		fill_addr = addr;
		fill_way = way;
		fill_data = rand_line();
		step();
		fill_valid = 1'b0;
	endtask

	task automatic do_inv(input logic all, input logic [ADDR_W-1:0] addr);
		inv_valid = 1'b1;
		inv_all = all;
		inv_addr = addr;
		step();
		inv_valid = 1'b0;
	endtask

	task automatic do_snoop(input logic [ADDR_W-1:0] addr, input logic [AGENT_ID_W-1:0] id);
		snoop_valid = 1'b1;
		snoop_addr = addr;
		snoop_id = id;
		step();
		snoop_valid = 1'b0;
	endtask

	// Random traffic on every port with back-pressure on the result
	task automatic run_random(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = draw();
			fetch_valid = (r[1:0] != 2'b00);
			fetch_addr = pool_addr();
			line_ready = (r[3:2] != 2'b00);
			fill_valid = (r[6:4] < 3'd2);
			fill_addr = pool_addr();
			fill_way = r[9:8];
			fill_data = rand_line();
			inv_valid = (r[15:11] == 5'd0);
			inv_all = r[16] & r[17];
			inv_addr = pool_addr();
			snoop_valid = (r[20:18] == 3'd0);
			snoop_addr = pool_addr();
			snoop_id = r[21] ? CACHE_ID : 6'd9;
			step();
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		seed = 32'h84db;
		clk = 1'b0;
		rst = 1'b1;
		idle_inputs();
		for (int b = 0; b < 2; b++)
			for (int w = 0; w < WAYS; w++)
				for (int s = 0; s < SETS; s++) begin
					m_vld[b][w][s] = 1'b0;
					m_tag[b][w][s] = '0;
					m_data[b][w][s] = '0;
				end
		exp_valid = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		// Every fetch to the empty cache misses on its even line, also across the set 63 wrap
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_fetch(make_addr(21'h2, 6'd10, 1'b1, 4'hE));
		do_fetch(make_addr(21'h1FFFFF, 6'd63, 1'b1, 4'h2));
		step();

		// A lone even line reports the odd line and the full pair hits from both starts
		do_fill(make_addr(21'h2, 6'd10, 1'b0, 4'h0), 2'd0);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_fill(make_addr(21'h2, 6'd10, 1'b1, 4'h0), 2'd1);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_fetch(make_addr(21'h2, 6'd10, 1'b1, 4'hE));
		do_fill(make_addr(21'h2, 6'd11, 1'b0, 4'h0), 2'd2);
		do_fetch(make_addr(21'h2, 6'd10, 1'b1, 4'hE));

		// The lower way supplies the data when a higher way holds the same tag
		do_fill(make_addr(21'h2, 6'd10, 1'b0, 4'h0), 2'd3);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h0));

		// Line invalidate in the odd bank leaves the even bank alone
		do_inv(1'b0, make_addr(21'h2, 6'd10, 1'b1, 4'h0));
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_fill(make_addr(21'h2, 6'd10, 1'b1, 4'h0), 2'd1);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_inv(1'b1, make_addr(21'h3, 6'd0, 1'b0, 4'h0));
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));

		// An own snoop is ignored and a foreign one clears the matching way
		do_fill(make_addr(21'h2, 6'd10, 1'b0, 4'h0), 2'd0);
		do_fill(make_addr(21'h2, 6'd10, 1'b1, 4'h0), 2'd1);
		do_snoop(make_addr(21'h2, 6'd10, 1'b1, 4'h0), CACHE_ID);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		do_snoop(make_addr(21'h2, 6'd10, 1'b1, 4'h0), 6'd9);
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));

		// Fill and foreign snoop of the same line in one cycle leave it invalid
		fill_valid = 1'b1;
		fill_addr = make_addr(21'h2, 6'd10, 1'b1, 4'h0);
		fill_way = 2'd2;
		fill_data = rand_line();
		snoop_valid = 1'b1;
		snoop_addr = make_addr(21'h2, 6'd10, 1'b1, 4'h0);
		snoop_id = 6'd9;
		step();
		fill_valid = 1'b0;
		snoop_valid = 1'b0;
		do_fetch(make_addr(21'h2, 6'd10, 1'b0, 4'h6));
		step();

		run_random(N_RANDOM);

		// Drain and check the last result
		idle_inputs();
		step();
		step();
		$display("test passed");
		$finish;
	end

endmodule

// ==== dual_bank_icache.sv ====
/*
 * Top level of the two-bank instruction cache
 * Fetch handshake, bank read addresses, strobe steering and the merge stage
 */
`timescale 1ns/1ns

module dual_bank_icache (
	input logic clk,
	input logic rst,
	input logic fetch_valid_i,
	input dual_bank_icache_pkg::fetch_addr_u fetch_addr_i,
	output logic fetch_ready_o,
	output logic line_valid_o,
	output logic [dual_bank_icache_pkg::LINE_W-1:0] line_lo_o,
	output logic [dual_bank_icache_pkg::LINE_W-1:0] line_hi_o,
	output logic hit_o,
	output logic [dual_bank_icache_pkg::ADDR_W-1:0] miss_addr_o,
	input logic line_ready_i,
	input logic fill_valid_i,
	input dual_bank_icache_pkg::fetch_addr_u fill_addr_i,
	input logic [dual_bank_icache_pkg::WAY_W-1:0] fill_way_i,
	input logic [dual_bank_icache_pkg::LINE_W-1:0] fill_data_i,
	input logic inv_valid_i,
	input logic inv_all_i,
	input dual_bank_icache_pkg::fetch_addr_u inv_addr_i,
	input logic snoop_valid_i,
	input dual_bank_icache_pkg::fetch_addr_u snoop_addr_i,
	input logic [dual_bank_icache_pkg::AGENT_ID_W-1:0] snoop_id_i
);
	import dual_bank_icache_pkg::*;

	logic accept;
	logic odd_first_q;
	fetch_addr_u even_rd_addr;
	fetch_addr_u odd_rd_addr;
	logic inv_all;
	logic inv_line;
	logic snoop_foreign;
	logic even_hit, odd_hit;
	logic [LINE_W-1:0] even_data, odd_data;
	fetch_addr_u even_addr, odd_addr;

	// ========================================================================
	// Fetch handshake
	// ========================================================================

	// A new request may enter whenever the result slot is empty or draining
	assign fetch_ready_o = !line_valid_o || line_ready_i;
	assign accept = fetch_valid_i && fetch_ready_o;

	always_ff @(posedge clk) begin
		if (rst)
			line_valid_o <= 1'b0;
		else if (fetch_ready_o)
			line_valid_o <= fetch_valid_i;
	end

	// Remembers which bank holds the low line of the pending result
	always_ff @(posedge clk) begin
		if (accept)
			odd_first_q <= fetch_addr_i.f.odd;
	end

	// Even line is the fetch line, or the next line when the fetch is odd
	// The add carries through the index into the tag at the end of a page
	always_comb begin
		even_rd_addr.flat = {fetch_addr_i.flat[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		if (fetch_addr_i.f.odd)
			even_rd_addr.flat = even_rd_addr.flat + ADDR_W'(LINE_BYTES);
	end

	// Odd line shares tag and set with the fetch in both cases
	always_comb begin
		odd_rd_addr = fetch_addr_i;
		odd_rd_addr.f.odd = 1'b1;
		odd_rd_addr.f.offset = '0;
	end

	// ========================================================================
	// Strobe steering
	// ========================================================================

	assign inv_all = inv_valid_i && inv_all_i;
	assign inv_line = inv_valid_i && !inv_all_i;

	// Own snoops are dropped here once for both banks
	assign snoop_foreign = snoop_valid_i && (snoop_id_i != CACHE_ID);

	icache_bank bank_even (
		.clk(clk),
		.rst(rst),
		.rd_en_i(accept),
		.rd_line_addr_i(even_rd_addr),
		.fill_en_i(fill_valid_i && !fill_addr_i.f.odd),
		.fill_addr_i(fill_addr_i),
		.fill_way_i(fill_way_i),
		.fill_data_i(fill_data_i),
		.inv_line_i(inv_line && !inv_addr_i.f.odd),
		.inv_all_i(inv_all),
		.inv_addr_i(inv_addr_i),
		.snoop_en_i(snoop_foreign && !snoop_addr_i.f.odd),
		.snoop_addr_i(snoop_addr_i),
		.hit_o(even_hit),
		.data_o(even_data),
		.line_addr_o(even_addr)
	);

	icache_bank bank_odd (
		.clk(clk),
		.rst(rst),
		.rd_en_i(accept),
		.rd_line_addr_i(odd_rd_addr),
		.fill_en_i(fill_valid_i && fill_addr_i.f.odd),
		.fill_addr_i(fill_addr_i),
		.fill_way_i(fill_way_i),
		.fill_data_i(fill_data_i),
		.inv_line_i(inv_line && inv_addr_i.f.odd),
		.inv_all_i(inv_all),
		.inv_addr_i(inv_addr_i),
		.snoop_en_i(snoop_foreign && snoop_addr_i.f.odd),
		.snoop_addr_i(snoop_addr_i),
		.hit_o(odd_hit),
		.data_o(odd_data),
		.line_addr_o(odd_addr)
	);

	icache_line_merge merge (
		.odd_first_i(odd_first_q),
		.even_hit_i(even_hit),
		.odd_hit_i(odd_hit),
		.even_data_i(even_data),
		.odd_data_i(odd_data),
		.even_addr_i(even_addr),
		.odd_addr_i(odd_addr),
		.line_lo_o(line_lo_o),
		.line_hi_o(line_hi_o),
		.hit_o(hit_o),
		.miss_addr_o(miss_addr_o)
	);

	// A stalled result must not change, across both banks and the merge
	result_hold: assert property (@(posedge clk) disable iff (rst)
		line_valid_o && !line_ready_i
		|=> $stable(line_lo_o) && $stable(line_hi_o) && $stable(hit_o));

endmodule

// ==== icache_line_merge.sv ====
/*
 * Merge stage of the two-bank instruction cache
 * Orders the even and odd bank lines, forms the pair hit and the miss address
 */
`timescale 1ns/1ns

module icache_line_merge (
	input logic odd_first_i,
	input logic even_hit_i,
	input logic odd_hit_i,
	input logic [dual_bank_icache_pkg::LINE_W-1:0] even_data_i,
	input logic [dual_bank_icache_pkg::LINE_W-1:0] odd_data_i,
	input dual_bank_icache_pkg::fetch_addr_u even_addr_i,
	input dual_bank_icache_pkg::fetch_addr_u odd_addr_i,
	output logic [dual_bank_icache_pkg::LINE_W-1:0] line_lo_o,
	output logic [dual_bank_icache_pkg::LINE_W-1:0] line_hi_o,
	output logic hit_o,
	output logic [dual_bank_icache_pkg::ADDR_W-1:0] miss_addr_o
);
	import dual_bank_icache_pkg::*;

	// ========================================================================
	// Line order
	// ========================================================================

	// A fetch that started in an odd line reads that line from the odd bank
	// and its successor from the even bank
	// A fetch that started in an even line is the other way round
	always_comb begin
		if (odd_first_i) begin
			line_lo_o = odd_data_i;
			line_hi_o = even_data_i;
		end else begin
			line_lo_o = even_data_i;
			line_hi_o = odd_data_i;
		end
	end

	// ========================================================================
	// Hit and miss address
	// ========================================================================

	// An instruction may span both lines, so both must be present
	assign hit_o = even_hit_i && odd_hit_i;

	// The even line is always asked for first, whichever line is lower in
	// the fetch, so the fill sequence is the same for both orders
	// The odd line is reported once the even line is present
	always_comb begin
		if (!even_hit_i)
			miss_addr_o = even_addr_i.flat;
		else if (!odd_hit_i)
			miss_addr_o = odd_addr_i.flat;
		else
			miss_addr_o = {ADDR_W{1'b0}};
	end

endmodule

// ==== icache_bank.sv ====
/*
 * One bank of the instruction cache
 * Tag, valid and data arrays for four ways, with the way compare
 * Fill, line and full invalidate, and snoop clear
 */
`timescale 1ns/1ns

module icache_bank (
	input logic clk,
	input logic rst,
	input logic rd_en_i,
	input dual_bank_icache_pkg::fetch_addr_u rd_line_addr_i,
	input logic fill_en_i,
	input dual_bank_icache_pkg::fetch_addr_u fill_addr_i,
	input logic [dual_bank_icache_pkg::WAY_W-1:0] fill_way_i,
	input logic [dual_bank_icache_pkg::LINE_W-1:0] fill_data_i,
	input logic inv_line_i,
	input logic inv_all_i,
	input dual_bank_icache_pkg::fetch_addr_u inv_addr_i,
	input logic snoop_en_i,
	input dual_bank_icache_pkg::fetch_addr_u snoop_addr_i,
	output logic hit_o,
	output logic [dual_bank_icache_pkg::LINE_W-1:0] data_o,
	output dual_bank_icache_pkg::fetch_addr_u line_addr_o
);
	import dual_bank_icache_pkg::*;

	// ========================================================================
	// Storage
	// ========================================================================

	// Tags are kept in flops so that all ways can be compared in one cycle
	logic [TAG_W-1:0] tag_mem [WAYS][SETS];

	// One valid bit per way and set
	logic [SETS-1:0] valid_q [WAYS];

	// Line data, addressed by way and set like a synchronous RAM
	logic [LINE_W-1:0] data_mem [WAYS*SETS];

	// Set indices of the four ports into the arrays
	logic [INDEX_W-1:0] rd_idx;
	logic [INDEX_W-1:0] fill_idx;
	logic [INDEX_W-1:0] inv_idx;
	logic [INDEX_W-1:0] snoop_idx;

	// Per-way results of the lookup and the snoop compare
	logic [WAYS-1:0] rd_match;
	logic [WAY_W-1:0] rd_way;
	logic [WAYS-1:0] snoop_clr;

	assign rd_idx = rd_line_addr_i.f.index;
	assign fill_idx = fill_addr_i.f.index;
	assign inv_idx = inv_addr_i.f.index;
	assign snoop_idx = snoop_addr_i.f.index;

	// ========================================================================
	// Lookup
	// ========================================================================

	// A way hits when it is valid at the set and holds the requested tag
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rd_match[w] = valid_q[w][rd_idx] && (tag_mem[w][rd_idx] == rd_line_addr_i.f.tag);
		end
	end

	// Walk from the top way down so the lowest matching way is the one kept
	always_comb begin
		rd_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (rd_match[w])
				rd_way = WAY_W'(w);
		end
	end

	// Hit flag is control state and starts cleared
	always_ff @(posedge clk) begin
		if (rst)
			hit_o <= 1'b0;
		else if (rd_en_i)
			hit_o <= |rd_match;
	end

	// Data and line address are payload and simply hold between reads
	// A fill on the same edge is not seen by this read, the RAM returns old data
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			data_o <= data_mem[{rd_way, rd_idx}];
			line_addr_o <= rd_line_addr_i;
		end
		if (fill_en_i)
			data_mem[{fill_way_i, fill_idx}] <= fill_data_i;
	end

	// ========================================================================
	// Tag and valid update
	// ========================================================================

	// A snoop clears every way at its set whose tag matches
	// A fill landing in the same cycle with the snooped line is stale, so it
	// is treated as a match too and the snoop clear overrides it
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			snoop_clr[w] = (tag_mem[w][snoop_idx] == snoop_addr_i.f.tag);
			if (fill_en_i && (fill_way_i == WAY_W'(w)) && (fill_idx == snoop_idx)
					&& (fill_addr_i.f.tag == snoop_addr_i.f.tag))
				snoop_clr[w] = 1'b1;
		end
	end

	// Tag written on fill only
	always_ff @(posedge clk) begin
		if (fill_en_i)
			tag_mem[fill_way_i][fill_idx] <= fill_addr_i.f.tag;
	end

	// Later assignments win, which gives snoop over fill over invalidate
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
		end else begin
			// Invalidate, lowest priority
			if (inv_all_i) begin
				for (int w = 0; w < WAYS; w++)
					valid_q[w] <= '0;
			end else if (inv_line_i) begin
				for (int w = 0; w < WAYS; w++)
					valid_q[w][inv_idx] <= 1'b0;
			end
			// Fill sets the chosen way
			if (fill_en_i)
				valid_q[fill_way_i][fill_idx] <= 1'b1;
			// Snoop clear, highest priority
			if (snoop_en_i) begin
				for (int w = 0; w < WAYS; w++) begin
					if (snoop_clr[w])
						valid_q[w][snoop_idx] <= 1'b0;
				end
			end
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// When a fill and a snoop clear meet at the same way and set, the entry
	// must be invalid on the next cycle
	fill_snoop_order: assert property (@(posedge clk) disable iff (rst)
		fill_en_i && snoop_en_i && (fill_idx == snoop_idx) && snoop_clr[fill_way_i]
		|=> !valid_q[$past(fill_way_i)][$past(fill_idx)]);

	// Read data only moves on a read
	data_hold: assert property (@(posedge clk) disable iff (rst)
		!rd_en_i |=> $stable(data_o));

endmodule

// ==== dual_bank_icache_pkg.sv ====
/*
 * Shared geometry of the two-bank instruction cache
 * Agent id of this cache for snoop filtering
 * Fetch address union with a flat view and a field view
 */
package dual_bank_icache_pkg;

	// ========================================================================
	// Address geometry
	// ========================================================================

	// Byte address width of a fetch
	localparam int ADDR_W = 32;

	// Byte offset within one 16-byte line
	localparam int OFFSET_W = 4;

	// Set index bits inside one bank
	localparam int INDEX_W = 6;

	// The bank bit sits between the index and the offset, so it is not part of the tag
	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W - 1;

	// Number of sets held by each bank
	localparam int SETS = 1 << INDEX_W;

	// Size of one line in bytes, used to step to the next line
	localparam int LINE_BYTES = 1 << OFFSET_W;

	// ========================================================================
	// Way and line storage
	// ========================================================================

	// Associativity of each bank
	localparam int WAYS = 4;
	localparam int WAY_W = 2;

	// One line of instruction bytes
	localparam int LINE_W = 128;

	// ========================================================================
	// Coherence agents
	// ========================================================================

	localparam int AGENT_ID_W = 6;

	// Snoops that come back with this id were caused by this cache itself
	localparam logic [AGENT_ID_W-1:0] CACHE_ID = 6'd1;

	// One address word, seen either as a plain number for arithmetic or
	// split into the fields that pick the bank, the set and the tag
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [INDEX_W-1:0] index;
			// High for lines stored in the odd bank
			logic odd;
			logic [OFFSET_W-1:0] offset;
		} f;
	} fetch_addr_u;

endpackage
